// File: src.f
src/epu_pkg.sv
src/epu_sram.sv
src/epu_buf_wrapper.sv
src/epu_host_decoder.sv
src/epu_engine.sv
src/epu_top.sv
sim/epu_checker.sv
sim/epu_tb.sv

// File: Bender.yml
package:
  name: epu

sources:
  - src/epu_pkg.sv
  - src/epu_sram.sv
  - src/epu_buf_wrapper.sv
  - src/epu_host_decoder.sv
  - src/epu_engine.sv
  - src/epu_top.sv
  - target: simulation
    files:
      - sim/epu_checker.sv
      - sim/epu_tb.sv

// File: sim/epu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module epu_tb;

  import epu_pkg::*;

  localparam int          CLK_PERIOD = 20;
  localparam int          N_RAND     = 64;
  localparam logic [31:0] LFSR_TAPS  = 32'hD000_0001;
  // Host operations plus run cycles over all phases
  localparam int          TEST_LEN   = 4*BUF_DEPTH + 2*N_RAND + 5*BUF_DEPTH + 64 + 5*BUF_DEPTH;

  logic               clk;
  logic               rst;
  logic               host_rd;
  logic               host_wr;
  logic [HADDR_W-1:0] host_addr;
  logic [HDATA_W-1:0] host_wdata;
  logic               host_rvalid;
  logic [HDATA_W-1:0] host_rdata;
  logic               start;
  logic [WIDX_W:0]    len;
  logic               busy;
  logic               done;
  logic [31:0]        lfsr;
  int                 checks;
  int                 errors;
  logic [1:0]         acc_sel [N_RAND];
  logic [WIDX_W-1:0]  acc_idx [N_RAND];

  epu_top #(.DEPTH(BUF_DEPTH)) u_epu_top (
    .clk           (clk),
    .rst           (rst),
    .host_rd_i     (host_rd),
    .host_wr_i     (host_wr),
    .host_addr_i   (host_addr),
    .host_wdata_i  (host_wdata),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .start_i       (start),
    .len_i         (len),
    .busy_o        (busy),
    .done_o        (done)
  );

  epu_checker u_checker (
    .clk (clk), .rst (rst),
    .host_rd_i (host_rd), .host_wr_i (host_wr),
    .host_addr_i (host_addr), .host_wdata_i (host_wdata),
    .rvalid_i (host_rvalid), .rdata_i (host_rdata),
    .start_i (start), .len_i (len), .busy_i (busy), .done_i (done),
    .checks_o (checks), .errors_o (errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
  endtask

  // Strobe for one cycle, next strobe no earlier than 3 cycles on
  task automatic host_write(input logic [1:0] sel, input logic [WIDX_W-1:0] idx,
                            input logic [31:0] data);
    @(negedge clk);
    host_wr    = 1'b1;
    host_addr  = {sel, idx, 2'b00};
    host_wdata = data;
    @(negedge clk);
    host_wr = 1'b0;
    @(negedge clk);
  endtask

  task automatic host_read(input logic [1:0] sel, input logic [WIDX_W-1:0] idx);
    @(negedge clk);
    host_rd   = 1'b1;
    host_addr = {sel, idx, 2'b00};
    @(negedge clk);
    host_rd = 1'b0;
    @(negedge clk);
  endtask

  task automatic write_random(input logic [1:0] sel, input logic [WIDX_W-1:0] idx);
    logic [31:0] d;
    rand_bits((sel < 2) ? 8 : 32, d);  // Weights and activations are 8 bits
    host_write(sel, idx, d);
  endtask

  task automatic pick_random(output logic [1:0] sel, output logic [WIDX_W-1:0] idx);
    logic [31:0] v;
    rand_bits(2, v);
    sel = v[1:0];
    rand_bits(WIDX_W, v);
    idx = v[WIDX_W-1:0];
  endtask

  task automatic start_run(input int n);
    @(negedge clk);
    start = 1'b1;
    len   = n[WIDX_W:0];
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_done;
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
    end
  endtask

  task automatic read_results;
    for (int k = 0; k < BUF_DEPTH; k++) host_read(BUF_RESULT, k[WIDX_W-1:0]);
  endtask

  initial begin
    logic [31:0] v;
    lfsr       = 32'd31;
    rst        = 1'b1;
    host_rd    = 1'b0;
    host_wr    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    start      = 1'b0;
    len        = '0;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    for (int s = 0; s < 4; s++) begin
      for (int k = 0; k < BUF_DEPTH; k++) write_random(s[1:0], k[WIDX_W-1:0]);
    end
    for (int k = 0; k < N_RAND; k++) begin
      pick_random(acc_sel[k], acc_idx[k]);
      write_random(acc_sel[k], acc_idx[k]);
    end
    for (int k = 0; k < N_RAND; k++) host_read(acc_sel[k], acc_idx[k]);

    rand_bits(WIDX_W, v);
    start_run(int'(v[WIDX_W-1:0]) + 1);
    wait_done();
    read_results();

    // Host traffic during a run must be dropped
    start_run(BUF_DEPTH);
    for (int k = 0; k < 8; k++) begin
      pick_random(acc_sel[k], acc_idx[k]);
      write_random(acc_sel[k], acc_idx[k]);
      host_read(acc_sel[k], acc_idx[k]);
    end
    wait_done();
    for (int k = 0; k < 8; k++) host_read(acc_sel[k], acc_idx[k]);
    read_results();

    start_run(1);
    wait_done();
    read_results();
    start_run(BUF_DEPTH);
    wait_done();
    read_results();

    start_run(BUF_DEPTH);
    rand_bits(6, v);
    repeat (int'(v[5:0]) + 10) @(negedge clk);
    rst = 1'b1;
    repeat (3) @(negedge clk);
    rst = 1'b0;
    for (int k = 0; k < 16; k++) begin
      pick_random(acc_sel[k], acc_idx[k]);
      host_read(acc_sel[k], acc_idx[k]);
    end
    for (int k = 0; k < 4; k++) begin
      pick_random(acc_sel[k], acc_idx[k]);
      write_random(BUF_RESULT, acc_idx[k]);
      host_read(BUF_RESULT, acc_idx[k]);
    end

    repeat (5) @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0 && checks > 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #((TEST_LEN * 4 + 1000) * CLK_PERIOD);
    $display("timeout: the test did not finish within %0d cycles", TEST_LEN * 4 + 1000);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim/epu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module epu_checker (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        host_rd_i,
  input  logic                        host_wr_i,
  input  logic [epu_pkg::HADDR_W-1:0] host_addr_i,
  input  logic [epu_pkg::HDATA_W-1:0] host_wdata_i,
  input  logic                        rvalid_i,
  input  logic [epu_pkg::HDATA_W-1:0] rdata_i,
  input  logic                        start_i,
  input  logic [epu_pkg::WIDX_W:0]    len_i,
  input  logic                        busy_i,
  input  logic                        done_i,
  output int                          checks_o,
  output int                          errors_o
);

  import epu_pkg::*;

  // Narrow words are kept sign-extended in all four buffers
  logic [HDATA_W-1:0] model [4][BUF_DEPTH];
  bit                 known [4][BUF_DEPTH];
  int                 rd_cyc_q [$];
  int                 rd_sel_q [$];
  int                 rd_idx_q [$];
  int                 cyc     = 0;
  int                 run_len = 0;
  int                 run_cyc = 0;
  bit                 running = 1'b0;
  int                 checks  = 0;
  int                 errors  = 0;

  assign checks_o = checks;
  assign errors_o = errors;

  task automatic compute_results(input int n);
    int w;
    int a;
    int b;
    for (int k = 0; k < n; k++) begin
      w = int'(model[BUF_WEIGHT][k]);
      a = int'(model[BUF_ACT][k]);
      b = int'(model[BUF_BIAS][k]);
      model[BUF_RESULT][k] = b + w * a;  // Wraps at 32 bits
      known[BUF_RESULT][k] = known[BUF_WEIGHT][k] && known[BUF_ACT][k] && known[BUF_BIAS][k];
    end
  endtask

  always @(posedge clk) begin
    int       c;
    int       s;
    int       i;
    buf_sel_e bsel;
    if (rst) begin
      if (rvalid_i || busy_i || done_i) begin
        errors++;
        $display("error: host_rvalid_o, busy_o, done_o during reset got %h expected %h",
                 {rvalid_i, busy_i, done_i}, 3'b000);
      end
      // Aborted run leaves a partly written result buffer
      if (running) begin
        for (int k = 0; k < run_len; k++) known[BUF_RESULT][k] = 1'b0;
      end
      running = 1'b0;
      rd_cyc_q.delete();
      rd_sel_q.delete();
      rd_idx_q.delete();
    end else begin
      if (rvalid_i) begin
        if (rd_cyc_q.size() == 0) begin
          errors++;
          $display("host_rvalid_o high at cycle %0d with no read pending", cyc);
        end else begin
          c = rd_cyc_q.pop_front();
          s = rd_sel_q.pop_front();
          i = rd_idx_q.pop_front();
          bsel = buf_sel_e'(s);
          checks++;
          if (cyc != c + 2) begin
            errors++;
            $display("read of %s[%0d] answered %0d cycles after the strobe instead of 2",
                     bsel.name(), i, cyc - c);
          end else if (known[s][i] && rdata_i !== model[s][i]) begin
            errors++;
            $display("error: host_rdata_o %s[%0d] got %h expected %h",
                     bsel.name(), i, rdata_i, model[s][i]);
          end
        end
      end
      if (rd_cyc_q.size() > 0 && cyc > rd_cyc_q[0] + 2) begin
        errors++;
        bsel = buf_sel_e'(rd_sel_q[0]);
        $display("read of %s[%0d] got no host_rvalid_o", bsel.name(), rd_idx_q[0]);
        void'(rd_cyc_q.pop_front());
        void'(rd_sel_q.pop_front());
        void'(rd_idx_q.pop_front());
      end
      s = int'(host_addr_i[HADDR_W-1 -: 2]);
      i = int'(host_addr_i[WIDX_W+1:2]);
      if (host_rd_i && !busy_i) begin
        rd_cyc_q.push_back(cyc);
        rd_sel_q.push_back(s);
        rd_idx_q.push_back(i);
      end
      if (host_wr_i && !busy_i) begin
        if (s < 2) model[s][i] = {{(HDATA_W-8){host_wdata_i[7]}}, host_wdata_i[7:0]};
        else model[s][i] = host_wdata_i;
        known[s][i] = 1'b1;
      end
      if (running && cyc == run_cyc + 1 && !busy_i) begin
        errors++;
        $display("error: busy_o after start_i got %h expected %h", busy_i, 1'b1);
      end
      if (done_i) begin
        checks++;
        if (!running) begin
          errors++;
          $display("done_o pulsed at cycle %0d without a run", cyc);
        end else begin
          if (cyc != run_cyc + run_len + 4) begin
            errors++;
            $display("done_o came %0d cycles after start_i, expected %0d",
                     cyc - run_cyc, run_len + 4);
          end
          if (busy_i) begin
            errors++;
            $display("error: busy_o in the done_o cycle got %h expected %h", busy_i, 1'b0);
          end
          compute_results(run_len);
          running = 1'b0;
        end
      end
      if (start_i && !busy_i) begin
        run_len = int'(len_i);
        run_cyc = cyc;
        running = 1'b1;
      end
    end
    cyc++;
  end

endmodule

`default_nettype wire

// File: src/epu_top.sv
`timescale 1ns/1ps
`default_nettype none

module epu_top #(
  parameter int DEPTH = epu_pkg::BUF_DEPTH
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        host_rd_i,
  input  logic                        host_wr_i,
  input  logic [epu_pkg::HADDR_W-1:0] host_addr_i,
  input  logic [epu_pkg::HDATA_W-1:0] host_wdata_i,
  output logic                        host_rvalid_o,
  output logic [epu_pkg::HDATA_W-1:0] host_rdata_o,
  input  logic                        start_i,
  input  logic [epu_pkg::WIDX_W:0]    len_i,
  output logic                        busy_o,
  output logic                        done_o
);

  import epu_pkg::*;

  logic [3:0]        enb;
  logic [WIDX_W-1:0] widx;
  logic [3:0]        rvalid;
  act_t              rdata_w, rdata_a;
  acc_t              rdata_b, rdata_r;

  logic              run_start, run_finish;
  logic              rd_cs;
  logic [WIDX_W-1:0] rd_addr;
  act_t              w_rdata, a_rdata;
  acc_t              b_rdata;
  logic              res_cs, res_wreq;
  logic [WIDX_W-1:0] res_addr;
  acc_t              res_wdata;

  epu_host_decoder u_host_decoder (
    .clk           (clk),
    .rst           (rst),
    .host_addr_i   (host_addr_i),
    .host_rd_i     (host_rd_i),
    .busy_i        (busy_o),
    .enb_o         (enb),
    .widx_o        (widx),
    .rvalid_i      (rvalid),
    .rdata_w_i     (rdata_w),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .rdata_r_i     (rdata_r),
    .host_rvalid_o (host_rvalid_o),
    .host_rdata_o  (host_rdata_o)
  );

  epu_engine u_engine (
    .clk          (clk),
    .rst          (rst),
    .start_i      (start_i),
    .len_i        (len_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .run_start_o  (run_start),
    .run_finish_o (run_finish),
    .rd_cs_o      (rd_cs),
    .rd_addr_o    (rd_addr),
    .w_rdata_i    (w_rdata),
    .a_rdata_i    (a_rdata),
    .b_rdata_i    (b_rdata),
    .res_cs_o     (res_cs),
    .res_wreq_o   (res_wreq),
    .res_addr_o   (res_addr),
    .res_wdata_o  (res_wdata)
  );

  // Input buffers are read only for the engine
  epu_buf_wrapper #(.word_t(act_t), .DEPTH(DEPTH)) u_buf_weight (
    .clk (clk), .rst (rst),
    .enb_i (enb[BUF_WEIGHT]), .host_rd_i (host_rd_i), .host_wr_i (host_wr_i),
    .widx_i (widx), .host_wdata_i (host_wdata_i[$bits(act_t)-1:0]),
    .rvalid_o (rvalid[BUF_WEIGHT]), .rdata_o (rdata_w),
    .run_start_i (run_start), .run_finish_i (run_finish),
    .epu_cs_i (rd_cs), .epu_wreq_i (1'b0), .epu_addr_i (rd_addr),
    .epu_wdata_i ('0), .epu_rdata_o (w_rdata)
  );

  epu_buf_wrapper #(.word_t(act_t), .DEPTH(DEPTH)) u_buf_act (
    .clk (clk), .rst (rst),
    .enb_i (enb[BUF_ACT]), .host_rd_i (host_rd_i), .host_wr_i (host_wr_i),
    .widx_i (widx), .host_wdata_i (host_wdata_i[$bits(act_t)-1:0]),
    .rvalid_o (rvalid[BUF_ACT]), .rdata_o (rdata_a),
    .run_start_i (run_start), .run_finish_i (run_finish),
    .epu_cs_i (rd_cs), .epu_wreq_i (1'b0), .epu_addr_i (rd_addr),
    .epu_wdata_i ('0), .epu_rdata_o (a_rdata)
  );

  epu_buf_wrapper #(.word_t(acc_t), .DEPTH(DEPTH)) u_buf_bias (
    .clk (clk), .rst (rst),
    .enb_i (enb[BUF_BIAS]), .host_rd_i (host_rd_i), .host_wr_i (host_wr_i),
    .widx_i (widx), .host_wdata_i (host_wdata_i),
    .rvalid_o (rvalid[BUF_BIAS]), .rdata_o (rdata_b),
    .run_start_i (run_start), .run_finish_i (run_finish),
    .epu_cs_i (rd_cs), .epu_wreq_i (1'b0), .epu_addr_i (rd_addr),
    .epu_wdata_i ('0), .epu_rdata_o (b_rdata)
  );

  // Result buffer is write only for the engine
  epu_buf_wrapper #(.word_t(acc_t), .DEPTH(DEPTH)) u_buf_result (
    .clk (clk), .rst (rst),
    .enb_i (enb[BUF_RESULT]), .host_rd_i (host_rd_i), .host_wr_i (host_wr_i),
    .widx_i (widx), .host_wdata_i (host_wdata_i),
    .rvalid_o (rvalid[BUF_RESULT]), .rdata_o (rdata_r),
    .run_start_i (run_start), .run_finish_i (run_finish),
    .epu_cs_i (res_cs), .epu_wreq_i (res_wreq), .epu_addr_i (res_addr),
    .epu_wdata_i (res_wdata), .epu_rdata_o ()
  );

endmodule

`default_nettype wire

// File: src/epu_engine.sv
`timescale 1ns/1ps
`default_nettype none

module epu_engine (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       start_i,
  input  logic [epu_pkg::WIDX_W:0]   len_i,
  output logic                       busy_o,
  output logic                       done_o,
  output logic                       run_start_o,
  output logic                       run_finish_o,
  // Shared read port of weight, activation and bias buffers
  output logic                       rd_cs_o,
  output logic [epu_pkg::WIDX_W-1:0] rd_addr_o,
  input  epu_pkg::act_t              w_rdata_i,
  input  epu_pkg::act_t              a_rdata_i,
  input  epu_pkg::acc_t              b_rdata_i,
  // Result buffer write port
  output logic                       res_cs_o,
  output logic                       res_wreq_o,
  output logic [epu_pkg::WIDX_W-1:0] res_addr_o,
  output epu_pkg::acc_t              res_wdata_o
);

  import epu_pkg::*;

  logic              busy_q;
  logic              done_q;
  logic              issuing_q;
  logic [WIDX_W-1:0] issue_cnt_q;
  logic [WIDX_W:0]   len_q;
  logic              last_issue;

  // Stage 0 read data, stage 1 product, stage 2 result write
  logic [2:0]        vld_q;
  logic [WIDX_W-1:0] idx_q [3];

  logic signed [2*$bits(act_t)-1:0] prod_q;
  acc_t                             bias_q;
  acc_t                             sum_q;

  assign run_start_o = start_i && !busy_q;  // Start while busy is dropped
  assign last_issue  = ({1'b0, issue_cnt_q} == len_q - 1'b1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      busy_q      <= 1'b0;
      done_q      <= 1'b0;
      issuing_q   <= 1'b0;
      issue_cnt_q <= '0;
      vld_q       <= '0;
    end else begin
      done_q <= run_finish_o;
      vld_q  <= {vld_q[1:0], issuing_q};
      if (run_start_o) begin
        busy_q      <= 1'b1;
        issuing_q   <= 1'b1;
        issue_cnt_q <= '0;
      end else begin
        if (issuing_q) begin
          issue_cnt_q <= issue_cnt_q + 1'b1;
          if (last_issue) issuing_q <= 1'b0;
        end
        if (run_finish_o) busy_q <= 1'b0;  // Drops with done
      end
    end
  end

  always_ff @(posedge clk) begin
    if (run_start_o) len_q <= len_i;
    idx_q[0] <= issue_cnt_q;
    idx_q[1] <= idx_q[0];
    idx_q[2] <= idx_q[1];
    prod_q   <= w_rdata_i * a_rdata_i;       // 8x8 signed, full width
    bias_q   <= b_rdata_i;
    sum_q    <= bias_q + acc_t'(prod_q);     // Wraps at 32 bits
  end

  assign busy_o       = busy_q;
  assign done_o       = done_q;
  assign rd_cs_o      = issuing_q;
  assign rd_addr_o    = issue_cnt_q;
  assign res_cs_o     = vld_q[2];
  assign res_wreq_o   = vld_q[2];
  assign res_addr_o   = idx_q[2];
  assign res_wdata_o  = sum_q;
  assign run_finish_o = vld_q[2] && ({1'b0, idx_q[2]} == len_q - 1'b1);

  a_res_addr_in_len : assert property (
    @(posedge clk) disable iff (rst)
    res_cs_o |-> ({1'b0, res_addr_o} <= len_q - 1'b1)
  ) else $error("epu_engine: result address %0d beyond len %0d", res_addr_o, len_q);

  a_len_nonzero : assert property (
    @(posedge clk) disable iff (rst) run_start_o |-> (len_i != '0)
  ) else $error("epu_engine: run started with len 0");

endmodule

`default_nettype wire

// File: src/epu_host_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module epu_host_decoder (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [epu_pkg::HADDR_W-1:0] host_addr_i,
  input  logic                        host_rd_i,
  input  logic                        busy_i,
  output logic [3:0]                  enb_o,
  output logic [epu_pkg::WIDX_W-1:0]  widx_o,
  input  logic [3:0]                  rvalid_i,
  input  epu_pkg::act_t               rdata_w_i,
  input  epu_pkg::act_t               rdata_a_i,
  input  epu_pkg::acc_t               rdata_b_i,
  input  epu_pkg::acc_t               rdata_r_i,
  output logic                        host_rvalid_o,
  output logic [epu_pkg::HDATA_W-1:0] host_rdata_o
);

  import epu_pkg::*;

  localparam int ACT_W = $bits(act_t);

  buf_sel_e sel;
  buf_sel_e rd_sel_q;

  assign sel    = buf_sel_e'(host_addr_i[HADDR_W-1 -: 2]);
  assign widx_o = host_addr_i[WIDX_W+1:2];  // Byte address to word index

  // Host is locked out for the whole run
  always_comb begin
    enb_o = '0;
    if (!busy_i) enb_o[sel] = 1'b1;
  end

  // Strobes are far enough apart that one pending read is enough
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rd_sel_q <= BUF_WEIGHT;
    end else if (host_rd_i) begin
      rd_sel_q <= sel;
    end
  end

  assign host_rvalid_o = |rvalid_i;

  always_comb begin
    case (rd_sel_q)
      BUF_WEIGHT: host_rdata_o = {{(HDATA_W-ACT_W){rdata_w_i[ACT_W-1]}}, rdata_w_i};
      BUF_ACT:    host_rdata_o = {{(HDATA_W-ACT_W){rdata_a_i[ACT_W-1]}}, rdata_a_i};
      BUF_BIAS:   host_rdata_o = rdata_b_i;
      default:    host_rdata_o = rdata_r_i;
    endcase
  end

endmodule

`default_nettype wire

// File: src/epu_buf_wrapper.sv
`timescale 1ns/1ps
`default_nettype none

module epu_buf_wrapper #(
  parameter type word_t = epu_pkg::acc_t,
  parameter int  DEPTH  = epu_pkg::BUF_DEPTH
) (
  input  logic                       clk,
  input  logic                       rst,
  // Host side
  input  logic                       enb_i,
  input  logic                       host_rd_i,
  input  logic                       host_wr_i,
  input  logic [epu_pkg::WIDX_W-1:0] widx_i,
  input  word_t                      host_wdata_i,
  output logic                       rvalid_o,
  output word_t                      rdata_o,
  // Engine side
  input  logic                       run_start_i,
  input  logic                       run_finish_i,
  input  logic                       epu_cs_i,
  input  logic                       epu_wreq_i,
  input  logic [epu_pkg::WIDX_W-1:0] epu_addr_i,
  input  word_t                      epu_wdata_i,
  output word_t                      epu_rdata_o
);

  import epu_pkg::*;

  buf_state_e state_q, state_d;

  logic              host_req;
  logic [WIDX_W-1:0] idx_q;
  word_t             wdata_q;

  logic              sram_cs;
  logic              sram_wreq;
  logic [WIDX_W-1:0] sram_addr;
  word_t             sram_wdata;
  word_t             sram_rdata;

  epu_sram #(
    .word_t (word_t),
    .DEPTH  (DEPTH)
  ) u_sram (
    .clk     (clk),
    .cs_i    (sram_cs),
    .wreq_i  (sram_wreq),
    .addr_i  (sram_addr),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  assign host_req = enb_i && (host_rd_i || host_wr_i);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (run_start_i) state_d = EPU_RW;  // Engine wins a tie with the host
        else if (enb_i && host_rd_i) state_d = HOST_AR;
        else if (enb_i && host_wr_i) state_d = HOST_W;
      end
      EPU_RW:  if (run_finish_i) state_d = IDLE;
      HOST_AR: state_d = HOST_R;
      HOST_R:  state_d = IDLE;
      HOST_W:  state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // Host may move on after the strobe
  always_ff @(posedge clk) begin
    if (state_q == IDLE && host_req) begin
      idx_q   <= widx_i;
      wdata_q <= host_wdata_i;
    end
  end

  always_comb begin
    sram_cs     = 1'b0;
    sram_wreq   = 1'b0;
    sram_addr   = '0;
    sram_wdata  = '0;
    rvalid_o    = 1'b0;
    rdata_o     = '0;
    epu_rdata_o = '0;
    case (state_q)
      EPU_RW: begin
        sram_cs     = epu_cs_i;
        sram_wreq   = epu_wreq_i;
        sram_addr   = epu_addr_i;
        sram_wdata  = epu_wdata_i;
        epu_rdata_o = sram_rdata;
      end
      HOST_AR: begin
        sram_cs   = 1'b1;       // Address phase
        sram_addr = idx_q;
      end
      HOST_R: begin
        rvalid_o = 1'b1;
        rdata_o  = sram_rdata;
      end
      HOST_W: begin
        sram_cs    = 1'b1;
        sram_wreq  = 1'b1;
        sram_addr  = idx_q;
        sram_wdata = wdata_q;
      end
      default: ;
    endcase
  end

  a_no_rd_wr_same_cycle : assert property (
    @(posedge clk) disable iff (rst) !(host_rd_i && host_wr_i)
  ) else $error("epu_buf_wrapper: read and write strobes together");

  // Engine must only start a run once every host access has drained
  a_start_in_idle : assert property (
    @(posedge clk) disable iff (rst) run_start_i |-> (state_q == IDLE)
  ) else $error("epu_buf_wrapper: run start in state %s", state_q.name());

endmodule

`default_nettype wire

// File: src/epu_sram.sv
`timescale 1ns/1ps
`default_nettype none

module epu_sram #(
  parameter type word_t = epu_pkg::acc_t,
  parameter int  DEPTH  = epu_pkg::BUF_DEPTH
) (
  input  logic                       clk,
  input  logic                       cs_i,
  input  logic                       wreq_i,
  input  logic [epu_pkg::WIDX_W-1:0] addr_i,
  input  word_t                      wdata_i,
  output word_t                      rdata_o
);

  word_t mem [DEPTH];
  word_t rdata_q;

  always_ff @(posedge clk) begin
    if (cs_i) begin
      if (wreq_i) begin
        mem[addr_i] <= wdata_i;
      end else begin
        rdata_q <= mem[addr_i];  // Registered read, data next cycle
      end
    end
  end

  assign rdata_o = rdata_q;

  // Index width can reach beyond a shallow array
  a_addr_in_range : assert property (
    @(posedge clk) cs_i |-> (int'(addr_i) < DEPTH)
  ) else $error("epu_sram: address %0d out of range", addr_i);

endmodule

`default_nettype wire

// File: src/epu_pkg.sv
`default_nettype none

package epu_pkg;

  // Buffer geometry
  localparam int BUF_DEPTH = 512;
  localparam int WIDX_W    = 9;     // Word index into a buffer

  // Host port
  localparam int HADDR_W   = 13;    // Bits 12..11 pick the buffer, 10..2 the word
  localparam int HDATA_W   = 32;

  typedef logic signed [7:0]  act_t;  // Weights and activations
  typedef logic signed [31:0] acc_t;  // Biases and results

  typedef enum logic [1:0] {
    BUF_WEIGHT = 2'd0,
    BUF_ACT    = 2'd1,
    BUF_BIAS   = 2'd2,
    BUF_RESULT = 2'd3
  } buf_sel_e;

  // Owner of the SRAM port inside a buffer wrapper
  typedef enum logic [2:0] {
    IDLE    = 3'd0,
    EPU_RW  = 3'd1,
    HOST_AR = 3'd2,
    HOST_R  = 3'd3,
    HOST_W  = 3'd4
  } buf_state_e;

endpackage

`default_nettype wire
